// File: common/stk_config.svh
`ifndef STK_CONFIG_SVH
`define STK_CONFIG_SVH

// Number of independent stacks sharing the slot pool
`define STK_ENGS_N 4

// Slot memory organisation
`define STK_BANKS_N 2
`define STK_LINES_N 8

// Stack data word width
`define STK_DAT_W 16

// Command and status field widths
`define STK_OP_W 2
`define STK_ST_W 2

// Opcodes, anything else is rejected
`define STK_OP_PUSH 0
`define STK_OP_POP 1

// Completion status codes
`define STK_ST_OKAY 0
`define STK_ST_ERR_EMPTY 1
`define STK_ST_ERR_FULL 2
`define STK_ST_BAD_OP 3

`endif

// File: common/stk_pkg.sv
`include "stk_config.svh"

package stk_pkg;

  // Engine (stack context) number
  typedef logic [$clog2(`STK_ENGS_N)-1:0] engid_t;

  // Bank and line within bank
  typedef logic [$clog2(`STK_BANKS_N)-1:0] bank_id_t;
  typedef logic [$clog2(`STK_LINES_N)-1:0] line_id_t;

  // Slot pointer, bank in the MSBs and line below
  typedef logic [$bits(bank_id_t)+$bits(line_id_t)-1:0] ptr_t;

  // Stack payload
  typedef logic [`STK_DAT_W-1:0] dat_t;

  // Command and completion codes
  typedef logic [`STK_OP_W-1:0] opcode_t;
  typedef logic [`STK_ST_W-1:0] status_t;

endpackage

// File: rtl/stk_free_list.sv
`timescale 1ns/1ns
`include "stk_config.svh"

module stk_free_list (
    input  logic          i_alloc
  , input  logic          i_free
  , input  stk_pkg::ptr_t i_free_ptr_in
  , output stk_pkg::ptr_t o_free_ptr
  , output logic          o_full
  , input  logic          clk
  , input  logic          i_rst_n
);
  import stk_pkg::*;

  localparam int SLOTS_N = `STK_BANKS_N * `STK_LINES_N;

  // One bit per slot, set while free
  logic [SLOTS_N-1:0] free_r;
  ptr_t               low_ptr;

  // Lowest free slot, scan from the top so the lowest wins
  always_comb begin
    low_ptr = '0;
    for (int s = SLOTS_N - 1; s >= 0; s--) begin
      if (free_r[s])
        low_ptr = ptr_t'(s);
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      free_r <= '1;
    end else begin
      if (i_free)
        free_r[i_free_ptr_in] <= 1'b1;
      // Alloc claims whatever is currently offered
      if (i_alloc)
        free_r[low_ptr] <= 1'b0;
    end
  end

  assign o_free_ptr = low_ptr;
  assign o_full     = ~|free_r;

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_alloc |-> !o_full);

  // Returned slot must have been handed out earlier
  a_no_double_free: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_free |-> !free_r[i_free_ptr_in]);

endmodule

// File: lk/stk_lookup.sv
`timescale 1ns/1ns
`include "stk_config.svh"

module stk_lookup (
    input  logic             i_cmd_req
  , input  stk_pkg::engid_t  i_cmd_engid
  , input  stk_pkg::opcode_t i_cmd_opcode
  , input  stk_pkg::dat_t    i_cmd_dat
  , output logic             o_cmd_ack
  // Free pool status
  , input  stk_pkg::ptr_t    i_free_ptr
  , input  logic             i_full
  // Table updates from writeback
  , input  logic             i_head_wen
  , input  logic             i_tail_wen
  , input  stk_pkg::engid_t  i_wr_engid
  , input  stk_pkg::ptr_t    i_head_ptr
  , input  stk_pkg::ptr_t    i_tail_ptr
  , input  logic             i_done
  // Uop towards memory
  , output logic             o_uc_vld
  , output stk_pkg::engid_t  o_uc_engid
  , output stk_pkg::opcode_t o_uc_opcode
  , output stk_pkg::status_t o_uc_status
  , output stk_pkg::dat_t    o_uc_dat
  , output stk_pkg::ptr_t    o_uc_ptr
  , output stk_pkg::ptr_t    o_uc_head
  , output logic             o_uc_was_empty
  , input  logic             clk
  , input  logic             i_rst_n
);
  import stk_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_ACK} state_t;

  state_t  state_r;
  state_t  state_nxt;
  logic    ack_r;

  // Command held for the duration of the transaction
  engid_t  cmd_engid_r;
  opcode_t cmd_opcode_r;
  dat_t    cmd_dat_r;

  // Per-engine context
  ptr_t    head_tbl_r [`STK_ENGS_N];
  ptr_t    tail_tbl_r [`STK_ENGS_N];
  logic [`STK_ENGS_N-1:0] empty_r;

  logic    accept;
  logic    issue;
  logic    is_push;
  logic    is_pop;
  logic    eng_empty;
  logic    good_push;
  logic    good_pop;
  ptr_t    cur_head;
  ptr_t    cur_tail;
  status_t status;

  assign accept = (state_r == ST_IDLE) & i_cmd_req;
  assign issue  = (state_r == ST_ISSUE);

  // Handshake FSM
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE:  if (i_cmd_req) state_nxt = ST_ISSUE;
      ST_ISSUE: state_nxt = ST_WAIT;
      ST_WAIT:  if (i_done) state_nxt = ST_ACK;
      ST_ACK:   if (!i_cmd_req) state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_r <= ST_IDLE;
      ack_r   <= 1'b0;
    end else begin
      state_r <= state_nxt;
      // Ack rises on writeback completion and falls once req is released
      if ((state_r == ST_WAIT) && i_done)
        ack_r <= 1'b1;
      else if ((state_r == ST_ACK) && !i_cmd_req)
        ack_r <= 1'b0;
    end
  end

  assign o_cmd_ack = ack_r;

  // Capture command on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_engid_r  <= i_cmd_engid;
      cmd_opcode_r <= i_cmd_opcode;
      cmd_dat_r    <= i_cmd_dat;
    end
  end

  // Head and tail tables written back after each good command
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      head_tbl_r <= '{default: '0};
      tail_tbl_r <= '{default: '0};
    end else begin
      if (i_head_wen)
        head_tbl_r[i_wr_engid] <= i_head_ptr;
      if (i_tail_wen)
        tail_tbl_r[i_wr_engid] <= i_tail_ptr;
    end
  end

  // Lookup of addressed engine
  assign cur_head  = head_tbl_r[cmd_engid_r];
  assign cur_tail  = tail_tbl_r[cmd_engid_r];
  assign eng_empty = empty_r[cmd_engid_r];

  assign is_push = (cmd_opcode_r == opcode_t'(`STK_OP_PUSH));
  assign is_pop  = (cmd_opcode_r == opcode_t'(`STK_OP_POP));

  // Status decision
  always_comb begin
    if (is_push)
      status = i_full ? status_t'(`STK_ST_ERR_FULL) : status_t'(`STK_ST_OKAY);
    else if (is_pop)
      status = eng_empty ? status_t'(`STK_ST_ERR_EMPTY) : status_t'(`STK_ST_OKAY);
    else
      status = status_t'(`STK_ST_BAD_OP);
  end

  assign good_push = issue & is_push & ~i_full;
  assign good_pop  = issue & is_pop & ~eng_empty;

  // Empty flag set when a pop removes the bottom entry where head meets tail
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n)
      empty_r <= '1;
    else if (good_push)
      empty_r[cmd_engid_r] <= 1'b0;
    else if (good_pop && (cur_head == cur_tail))
      empty_r[cmd_engid_r] <= 1'b1;
  end

  // Uop is live for the single ISSUE cycle
  assign o_uc_vld       = issue;
  assign o_uc_engid     = cmd_engid_r;
  assign o_uc_opcode    = cmd_opcode_r;
  assign o_uc_status    = status;
  assign o_uc_dat       = cmd_dat_r;
  assign o_uc_ptr       = i_free_ptr;
  assign o_uc_head      = cur_head;
  assign o_uc_was_empty = eng_empty;

  a_no_ack_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    (state_r == ST_IDLE) |-> !o_cmd_ack);

endmodule

// File: mem/stk_mem.sv
`timescale 1ns/1ns
`include "stk_config.svh"

module stk_mem (
    input  logic             i_uc_vld
  , input  stk_pkg::engid_t  i_uc_engid
  , input  stk_pkg::opcode_t i_uc_opcode
  , input  stk_pkg::status_t i_uc_status
  , input  stk_pkg::dat_t    i_uc_dat
  , input  stk_pkg::ptr_t    i_uc_ptr
  , input  stk_pkg::ptr_t    i_uc_head
  , input  logic             i_uc_was_empty
  // Uop plus read results towards writeback
  , output logic             o_wb_vld
  , output stk_pkg::engid_t  o_wb_engid
  , output stk_pkg::opcode_t o_wb_opcode
  , output stk_pkg::status_t o_wb_status
  , output stk_pkg::ptr_t    o_wb_ptr
  , output stk_pkg::ptr_t    o_wb_head
  , output logic             o_wb_was_empty
  , output stk_pkg::ptr_t    o_wb_prev
  , output stk_pkg::dat_t    o_wb_dat
  , input  logic             clk
  , input  logic             i_rst_n
);
  import stk_pkg::*;

  logic     ok;
  logic     is_push;
  ptr_t     acc_ptr;
  bank_id_t acc_bank;
  line_id_t acc_line;
  bank_id_t rd_bank_r;
  logic [`STK_BANKS_N-1:0] bank_ce;

  // Registered read data per bank
  ptr_t     prev_q [`STK_BANKS_N];
  dat_t     dat_q  [`STK_BANKS_N];

  // Failed commands touch no memory
  assign ok      = i_uc_vld & (i_uc_status == status_t'(`STK_ST_OKAY));
  assign is_push = (i_uc_opcode == opcode_t'(`STK_OP_PUSH));

  // Push targets the new slot while pop reads the current head
  assign acc_ptr  = is_push ? i_uc_ptr : i_uc_head;
  assign acc_bank = bank_id_t'(acc_ptr >> $bits(line_id_t));
  assign acc_line = line_id_t'(acc_ptr);

  for (genvar b = 0; b < `STK_BANKS_N; b++) begin : g_bank
    ptr_t prev_mem [`STK_LINES_N];
    dat_t dat_mem  [`STK_LINES_N];

    assign bank_ce[b] = ok & (acc_bank == bank_id_t'(b));

    always_ff @(posedge clk) begin
      if (bank_ce[b]) begin
        if (is_push) begin
          // Link new slot down to the old head
          prev_mem[acc_line] <= i_uc_head;
          dat_mem[acc_line]  <= i_uc_dat;
        end else begin
          prev_q[b] <= prev_mem[acc_line];
          dat_q[b]  <= dat_mem[acc_line];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_wb_vld <= 1'b0;
    else
      o_wb_vld <= i_uc_vld;
  end

  // Uop payload carried alongside the read
  always_ff @(posedge clk) begin
    if (i_uc_vld) begin
      o_wb_engid     <= i_uc_engid;
      o_wb_opcode    <= i_uc_opcode;
      o_wb_status    <= i_uc_status;
      o_wb_ptr       <= i_uc_ptr;
      o_wb_head      <= i_uc_head;
      o_wb_was_empty <= i_uc_was_empty;
      rd_bank_r      <= acc_bank;
    end
  end

  assign o_wb_prev = prev_q[rd_bank_r];
  assign o_wb_dat  = dat_q[rd_bank_r];

  // At most one bank enabled per access
  a_one_bank: assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0(bank_ce));

endmodule

// File: wrbk/stk_wrbk.sv
`timescale 1ns/1ns
`include "stk_config.svh"

module stk_wrbk (
    input  logic             i_wb_vld
  , input  stk_pkg::engid_t  i_wb_engid
  , input  stk_pkg::opcode_t i_wb_opcode
  , input  stk_pkg::status_t i_wb_status
  , input  stk_pkg::ptr_t    i_wb_ptr
  , input  stk_pkg::ptr_t    i_wb_head
  , input  logic             i_wb_was_empty
  , input  stk_pkg::ptr_t    i_wb_prev
  , input  stk_pkg::dat_t    i_wb_dat
  // Table updates back to lookup
  , output logic             o_head_wen
  , output logic             o_tail_wen
  , output stk_pkg::engid_t  o_wr_engid
  , output stk_pkg::ptr_t    o_head_ptr
  , output stk_pkg::ptr_t    o_tail_ptr
  // Free pool
  , output logic             o_alloc
  , output logic             o_free
  , output stk_pkg::ptr_t    o_free_ptr_out
  // Response
  , output stk_pkg::status_t o_rsp_status
  , output stk_pkg::dat_t    o_rsp_dat
  , output logic             o_done
  , input  logic             clk
  , input  logic             i_rst_n
);
  import stk_pkg::*;

  logic ok;
  logic push_ok;
  logic pop_ok;

  assign ok      = i_wb_vld & (i_wb_status == status_t'(`STK_ST_OKAY));
  assign push_ok = ok & (i_wb_opcode == opcode_t'(`STK_OP_PUSH));
  assign pop_ok  = ok & (i_wb_opcode == opcode_t'(`STK_OP_POP));

  // New slot becomes head on push, previous link on pop
  assign o_head_wen = push_ok | pop_ok;
  assign o_head_ptr = push_ok ? i_wb_ptr : i_wb_prev;
  assign o_wr_engid = i_wb_engid;

  // Tail only moves when the first entry goes in
  assign o_tail_wen = push_ok & i_wb_was_empty;
  assign o_tail_ptr = i_wb_ptr;

  // Slot accounting
  assign o_alloc        = push_ok;
  assign o_free         = pop_ok;
  assign o_free_ptr_out = i_wb_head;

  // Response holds until the next completion
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rsp_status <= status_t'(`STK_ST_OKAY);
      o_rsp_dat    <= '0;
      o_done       <= 1'b0;
    end else begin
      o_done <= i_wb_vld;
      if (i_wb_vld) begin
        o_rsp_status <= i_wb_status;
        o_rsp_dat    <= pop_ok ? i_wb_dat : '0;
      end
    end
  end

endmodule

// File: rtl/stk_engine.sv
`timescale 1ns/1ns

module stk_engine (
    input  logic             i_cmd_req
  , input  stk_pkg::engid_t  i_cmd_engid
  , input  stk_pkg::opcode_t i_cmd_opcode
  , input  stk_pkg::dat_t    i_cmd_dat
  , output logic             o_cmd_ack
  , output stk_pkg::status_t o_rsp_status
  , output stk_pkg::dat_t    o_rsp_dat
  , input  logic             clk
  , input  logic             i_rst_n
);
  import stk_pkg::*;

  // Lookup to memory uop
  logic    uc_vld;
  engid_t  uc_engid;
  opcode_t uc_opcode;
  status_t uc_status;
  dat_t    uc_dat;
  ptr_t    uc_ptr;
  ptr_t    uc_head;
  logic    uc_was_empty;

  // Memory to writeback uop
  logic    wb_vld;
  engid_t  wb_engid;
  opcode_t wb_opcode;
  status_t wb_status;
  ptr_t    wb_ptr;
  ptr_t    wb_head;
  logic    wb_was_empty;
  ptr_t    wb_prev;
  dat_t    wb_dat;

  // Table update path back into lookup
  logic    head_wen;
  logic    tail_wen;
  engid_t  wr_engid;
  ptr_t    head_ptr;
  ptr_t    tail_ptr;
  logic    done;

  // Free slot pool
  logic    alloc;
  logic    free;
  ptr_t    free_ptr_ret;
  ptr_t    free_ptr;
  logic    full;

  stk_lookup u_lookup (
      .i_cmd_req (i_cmd_req), .i_cmd_engid (i_cmd_engid), .i_cmd_opcode (i_cmd_opcode)
    , .i_cmd_dat (i_cmd_dat), .o_cmd_ack (o_cmd_ack)
    , .i_free_ptr (free_ptr), .i_full (full)
    , .i_head_wen (head_wen), .i_tail_wen (tail_wen), .i_wr_engid (wr_engid)
    , .i_head_ptr (head_ptr), .i_tail_ptr (tail_ptr), .i_done (done)
    , .o_uc_vld (uc_vld), .o_uc_engid (uc_engid), .o_uc_opcode (uc_opcode)
    , .o_uc_status (uc_status), .o_uc_dat (uc_dat), .o_uc_ptr (uc_ptr)
    , .o_uc_head (uc_head), .o_uc_was_empty (uc_was_empty)
    , .clk (clk), .i_rst_n (i_rst_n)
  );

  stk_free_list u_free_list (
      .i_alloc (alloc), .i_free (free), .i_free_ptr_in (free_ptr_ret)
    , .o_free_ptr (free_ptr), .o_full (full)
    , .clk (clk), .i_rst_n (i_rst_n)
  );

  stk_mem u_mem (
      .i_uc_vld (uc_vld), .i_uc_engid (uc_engid), .i_uc_opcode (uc_opcode)
    , .i_uc_status (uc_status), .i_uc_dat (uc_dat), .i_uc_ptr (uc_ptr)
    , .i_uc_head (uc_head), .i_uc_was_empty (uc_was_empty)
    , .o_wb_vld (wb_vld), .o_wb_engid (wb_engid), .o_wb_opcode (wb_opcode)
    , .o_wb_status (wb_status), .o_wb_ptr (wb_ptr), .o_wb_head (wb_head)
    , .o_wb_was_empty (wb_was_empty), .o_wb_prev (wb_prev), .o_wb_dat (wb_dat)
    , .clk (clk), .i_rst_n (i_rst_n)
  );

  stk_wrbk u_wrbk (
      .i_wb_vld (wb_vld), .i_wb_engid (wb_engid), .i_wb_opcode (wb_opcode)
    , .i_wb_status (wb_status), .i_wb_ptr (wb_ptr), .i_wb_head (wb_head)
    , .i_wb_was_empty (wb_was_empty), .i_wb_prev (wb_prev), .i_wb_dat (wb_dat)
    , .o_head_wen (head_wen), .o_tail_wen (tail_wen), .o_wr_engid (wr_engid)
    , .o_head_ptr (head_ptr), .o_tail_ptr (tail_ptr)
    , .o_alloc (alloc), .o_free (free), .o_free_ptr_out (free_ptr_ret)
    , .o_rsp_status (o_rsp_status), .o_rsp_dat (o_rsp_dat), .o_done (done)
    , .clk (clk), .i_rst_n (i_rst_n)
  );

endmodule

// File: sim/stk_engine_tb.sv
`timescale 1ns/1ns
`include "stk_config.svh"

module stk_engine_tb;
  import stk_pkg::*;

  localparam int SLOTS_N     = `STK_BANKS_N * `STK_LINES_N;
  localparam int RST_CYC     = 16;
  localparam int RAND_CMDS   = 1900;
  // Directed section plus random section stays below this
  localparam int CMDS_MAX    = 2000;
  localparam int TIMEOUT_CYC = CMDS_MAX * 10 + RST_CYC;

  logic    clk = 1'b0;
  logic    i_rst_n;
  logic    cmd_req;
  engid_t  cmd_engid;
  opcode_t cmd_opcode;
  dat_t    cmd_dat;
  logic    cmd_ack;
  status_t rsp_status;
  dat_t    rsp_dat;

  logic [31:0] lcg_state = 32'h7ae5;
  int          cyc_cnt = 0;

  // Reference model with one LIFO per engine and a shared slot count
  dat_t model_mem [`STK_ENGS_N][SLOTS_N];
  int   model_cnt [`STK_ENGS_N];
  int   used_cnt;

  stk_engine dut_i (
      .i_cmd_req (cmd_req), .i_cmd_engid (cmd_engid), .i_cmd_opcode (cmd_opcode)
    , .i_cmd_dat (cmd_dat), .o_cmd_ack (cmd_ack)
    , .o_rsp_status (rsp_status), .o_rsp_dat (rsp_dat)
    , .clk (clk), .i_rst_n (i_rst_n)
  );

  always #5 clk = ~clk;

  // Run limit allows at most ten cycles per command plus reset
  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Fail %s: expected %0h actual %0h", name, exp_val, act_val);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Four-phase transfer of one command
  task automatic send_cmd(input engid_t eng, input opcode_t op, input dat_t dat,
                          output status_t st, output dat_t rd);
    logic [31:0] r;
    @(posedge clk);
    cmd_req    <= 1'b1;
    cmd_engid  <= eng;
    cmd_opcode <= op;
    cmd_dat    <= dat;
    @(posedge clk);
    while (!cmd_ack)
      @(posedge clk);
    st = rsp_status;
    rd = rsp_dat;
    r  = next_rand();
    // Ack has to stay up while req is held
    if (r[20]) begin
      @(posedge clk);
      compare_value("ack held while req high", 1, cmd_ack);
    end
    cmd_req <= 1'b0;
    @(posedge clk);
    while (cmd_ack)
      @(posedge clk);
    // Ack stays low during an idle gap with req low
    if (r[21]) begin
      @(posedge clk);
      compare_value("ack low while idle", 0, cmd_ack);
    end
  endtask

  // Predict from the model, run the command and compare
  task automatic run_cmd(input string name, input engid_t eng, input opcode_t op,
                         input dat_t dat);
    status_t exp_st;
    dat_t    exp_dat;
    status_t got_st;
    dat_t    got_dat;
    exp_dat = '0;
    if (op == opcode_t'(`STK_OP_PUSH)) begin
      if (used_cnt == SLOTS_N) begin
        exp_st = status_t'(`STK_ST_ERR_FULL);
      end else begin
        exp_st = status_t'(`STK_ST_OKAY);
        model_mem[eng][model_cnt[eng]] = dat;
        model_cnt[eng] = model_cnt[eng] + 1;
        used_cnt = used_cnt + 1;
      end
    end else if (op == opcode_t'(`STK_OP_POP)) begin
      if (model_cnt[eng] == 0) begin
        exp_st = status_t'(`STK_ST_ERR_EMPTY);
      end else begin
        exp_st = status_t'(`STK_ST_OKAY);
        model_cnt[eng] = model_cnt[eng] - 1;
        exp_dat = model_mem[eng][model_cnt[eng]];
        used_cnt = used_cnt - 1;
      end
    end else begin
      exp_st = status_t'(`STK_ST_BAD_OP);
    end
    send_cmd(eng, op, dat, got_st, got_dat);
    compare_value({name, " status"}, exp_st, got_st);
    compare_value({name, " data"}, exp_dat, got_dat);
  endtask

  initial begin
    logic [31:0] r;
    opcode_t     op;
    cmd_req    = 1'b0;
    cmd_engid  = '0;
    cmd_opcode = '0;
    cmd_dat    = '0;
    used_cnt   = 0;
    for (int e = 0; e < `STK_ENGS_N; e++)
      model_cnt[e] = 0;
    i_rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    i_rst_n <= 1'b1;
    @(posedge clk);
    compare_value("ack after reset", 0, cmd_ack);
    compare_value("status after reset", `STK_ST_OKAY, rsp_status);
    compare_value("data after reset", 0, rsp_dat);

    // Every engine starts empty
    for (int e = 0; e < `STK_ENGS_N; e++)
      run_cmd("empty pop", engid_t'(e), opcode_t'(`STK_OP_POP), '0);

    // LIFO order on two engines at once
    for (int i = 0; i < 3; i++)
      run_cmd("lifo push e0", 2'd0, opcode_t'(`STK_OP_PUSH), dat_t'(16'h1a00 + i));
    for (int i = 0; i < 2; i++)
      run_cmd("lifo push e1", 2'd1, opcode_t'(`STK_OP_PUSH), dat_t'(16'h2b00 + i));
    for (int i = 0; i < 4; i++)
      run_cmd("lifo pop e0", 2'd0, opcode_t'(`STK_OP_POP), '0);
    for (int i = 0; i < 3; i++)
      run_cmd("lifo pop e1", 2'd1, opcode_t'(`STK_OP_POP), '0);

    // Unknown opcodes leave the stacks alone
    run_cmd("bad op push", 2'd2, opcode_t'(`STK_OP_PUSH), 16'h3c3c);
    run_cmd("bad op 2", 2'd2, opcode_t'(2), 16'hdead);
    run_cmd("bad op 3", 2'd2, opcode_t'(3), 16'hbeef);
    run_cmd("bad op pop", 2'd2, opcode_t'(`STK_OP_POP), '0);

    // Fill every slot, then overflow and reuse one slot
    for (int i = 0; i < SLOTS_N; i++)
      run_cmd("fill push", engid_t'(i), opcode_t'(`STK_OP_PUSH), dat_t'(16'h4000 + i * 7));
    run_cmd("full push", 2'd3, opcode_t'(`STK_OP_PUSH), 16'h5555);
    run_cmd("pop from full", 2'd1, opcode_t'(`STK_OP_POP), '0);
    run_cmd("reuse push", 2'd3, opcode_t'(`STK_OP_PUSH), 16'h6666);
    run_cmd("full again", 2'd0, opcode_t'(`STK_OP_PUSH), 16'h7777);
    for (int e = 0; e < `STK_ENGS_N; e++)
      while (model_cnt[e] > 0)
        run_cmd("drain pop", engid_t'(e), opcode_t'(`STK_OP_POP), '0);

    // Random mix with pushes slightly favoured so the pool fills up
    for (int n = 0; n < RAND_CMDS; n++) begin
      r = next_rand();
      if (r[27:24] == 4'd0)
        op = opcode_t'(2 + r[28]);
      else if (r[27:24] <= 4'd8)
        op = opcode_t'(`STK_OP_PUSH);
      else
        op = opcode_t'(`STK_OP_POP);
      run_cmd("random", engid_t'(r[31:30]), op, dat_t'(r[23:8]));
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+common
common/stk_pkg.sv
rtl/stk_free_list.sv
lk/stk_lookup.sv
mem/stk_mem.sv
wrbk/stk_wrbk.sv
rtl/stk_engine.sv
sim/stk_engine_tb.sv
